//--- Bender.yml
package:
  name: cpu_top

sources:
  - cpu_pkg.sv
  - apb_if.sv
  - fetch_unit.sv
  - decode_unit.sv
  - pipe_id_ex.sv
  - execute_unit.sv
  - mem_arbiter.sv
  - unified_mem.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_cpu_top.sv

//--- apb_if.sv
`timescale 1ns/1ps

interface apb_if;

  logic [cpu_pkg::ADDR_W-1:0] paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [cpu_pkg::DATA_W-1:0] pwdata;
  logic [cpu_pkg::DATA_W-1:0] prdata;  // valid with pready
  logic                       pready;

  modport master (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready
  );

  modport slave (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready
  );

endinterface

//--- cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////
  // sizes
  localparam int DATA_W    = 16;
  localparam int ADDR_W    = 16;
  localparam int MEM_DEPTH = 256;  // words
  localparam int REG_W     = 3;
  localparam int NUM_REGS  = 8;

  //////////////////////////////
  // opcodes, top five bits of every word
  localparam logic [4:0] OP_HALT  = 5'b00000;
  localparam logic [4:0] OP_NOP   = 5'b00001;
  localparam logic [4:0] OP_ADDI  = 5'b01000;  // rd = rs + sext(imm)
  localparam logic [4:0] OP_ST    = 5'b10000;  // mem[rs + sext(imm)] = rd
  localparam logic [4:0] OP_LD    = 5'b10001;  // rd = mem[rs + sext(imm)]
  localparam logic [4:0] OP_RTYPE = 5'b11011;  // rd = rs fn rt

  // r-type function codes
  localparam logic [1:0] FN_ADD = 2'b00;
  localparam logic [1:0] FN_SUB = 2'b01;  // rs - rt
  localparam logic [1:0] FN_XOR = 2'b10;
  localparam logic [1:0] FN_AND = 2'b11;

  localparam logic [DATA_W-1:0] NOP_WORD = {OP_NOP, 11'b0};  // 16'h0800

  //////////////////////////////
  // instruction formats
  typedef struct packed {
    logic [4:0]       opcode;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [1:0]       funct;
  } instr_r_t;

  typedef struct packed {
    logic [4:0]       opcode;
    logic [REG_W-1:0] rd;
    logic [REG_W-1:0] rs;
    logic [4:0]       imm;  // sign extended
  } instr_i_t;

  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_u;

  // one decoded instruction on its way to execute
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] instr;
    logic [1:0]        alu_fn;
    logic              alu_src;  // 1 selects imm as the second operand
    logic              reg_write;
    logic              mem_read;
    logic              mem_write;
    logic              halt;
    logic [REG_W-1:0]  rd;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] store_data;
    logic [DATA_W-1:0] imm;
  } id_ex_t;

  localparam id_ex_t ID_EX_BUBBLE = '{instr: NOP_WORD, default: '0};

endpackage

//--- cpu_top.f
cpu_pkg.sv
apb_if.sv
fetch_unit.sv
decode_unit.sv
pipe_id_ex.sv
execute_unit.sv
mem_arbiter.sv
unified_mem.sv
cpu_top.sv
tb_cpu_top.sv

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       run_i,
  input  logic [cpu_pkg::ADDR_W-1:0] host_paddr_i,
  input  logic                       host_psel_i,
  input  logic                       host_penable_i,
  input  logic                       host_pwrite_i,
  input  logic [cpu_pkg::DATA_W-1:0] host_pwdata_i,
  output logic [cpu_pkg::DATA_W-1:0] host_prdata_o,
  output logic                       host_pready_o,
  output logic                       halted_o
);

  logic [cpu_pkg::DATA_W-1:0] if_instr;
  logic                       if_valid;
  logic                       decode_hold;
  logic                       stop_fetch;
  logic                       stall_decode;
  logic                       ex_busy;
  logic                       wb_en;
  logic [cpu_pkg::REG_W-1:0]  wb_rd;
  logic [cpu_pkg::DATA_W-1:0] wb_data;
  cpu_pkg::id_ex_t            id_next;
  cpu_pkg::id_ex_t            id_ex_q;

  apb_if fetch_bus ();
  apb_if data_bus ();
  apb_if mem_bus ();
  apb_if host_bus ();

  // host port onto its own bus
  assign host_bus.paddr   = host_paddr_i;
  assign host_bus.psel    = host_psel_i;
  assign host_bus.penable = host_penable_i;
  assign host_bus.pwrite  = host_pwrite_i;
  assign host_bus.pwdata  = host_pwdata_i;
  assign host_prdata_o    = host_bus.prdata;
  assign host_pready_o    = host_bus.pready;

  fetch_unit fetch_i (
    .clk(clk), .reset_i(reset_i), .run_i(run_i), .decode_hold_i(decode_hold),
    .stop_fetch_i(stop_fetch), .bus(fetch_bus),
    .if_instr_o(if_instr), .if_valid_o(if_valid)
  );

  decode_unit decode_i (
    .clk(clk), .reset_i(reset_i), .if_instr_i(if_instr), .if_valid_i(if_valid),
    .ex_busy_i(ex_busy), .wb_en_i(wb_en), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
    .ex_rd_i(id_ex_q.rd), .ex_reg_write_i(id_ex_q.reg_write),
    .id_next_o(id_next), .stall_decode_o(stall_decode),
    .decode_hold_o(decode_hold), .stop_fetch_o(stop_fetch)
  );

  pipe_id_ex pipe_i (
    .clk(clk), .reset_i(reset_i), .id_next_i(id_next),
    .stall_decode_i(stall_decode), .ex_busy_i(ex_busy), .id_ex_o(id_ex_q)
  );

  execute_unit execute_i (
    .clk(clk), .reset_i(reset_i), .id_ex_i(id_ex_q), .bus(data_bus),
    .ex_busy_o(ex_busy), .wb_en_o(wb_en), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
    .halted_o(halted_o)
  );

  mem_arbiter arbiter_i (
    .clk(clk), .reset_i(reset_i), .host_bus(host_bus), .data_bus(data_bus),
    .fetch_bus(fetch_bus), .mem_bus(mem_bus)
  );

  unified_mem mem_i (.clk(clk), .reset_i(reset_i), .bus(mem_bus));

endmodule

//--- decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
  input  logic                        clk,
  input  logic                        reset_i,
  input  logic [cpu_pkg::DATA_W-1:0]  if_instr_i,
  input  logic                        if_valid_i,
  input  logic                        ex_busy_i,
  input  logic                        wb_en_i,
  input  logic [cpu_pkg::REG_W-1:0]   wb_rd_i,
  input  logic [cpu_pkg::DATA_W-1:0]  wb_data_i,
  input  logic [cpu_pkg::REG_W-1:0]   ex_rd_i,
  input  logic                        ex_reg_write_i,
  output cpu_pkg::id_ex_t             id_next_o,
  output logic                        stall_decode_o,
  output logic                        decode_hold_o,
  output logic                        stop_fetch_o
);

  cpu_pkg::instr_u               iw;
  cpu_pkg::id_ex_t               dec;
  logic [4:0]                    opc;
  logic [cpu_pkg::REG_W-1:0]     rb;  // rt, or rd for a store
  logic [cpu_pkg::DATA_W-1:0]    rdata_a;
  logic [cpu_pkg::DATA_W-1:0]    rdata_b;
  logic [cpu_pkg::DATA_W-1:0]    rf [cpu_pkg::NUM_REGS];
  logic                          uses_a;
  logic                          uses_b;
  logic                          dec_valid;
  logic                          hazard;
  logic                          halt_seen_q;

  assign iw  = if_instr_i;
  assign opc = iw.r.opcode;
  assign rb  = (opc == cpu_pkg::OP_ST) ? iw.i.rd : iw.r.rt;

  //////////////////////////////
  // register file, two reads and one write with bypass
  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int k = 0; k < cpu_pkg::NUM_REGS; k++) rf[k] <= '0;
    end else if (wb_en_i) begin
      rf[wb_rd_i] <= wb_data_i;
    end
  end

  assign rdata_a = (wb_en_i && wb_rd_i == iw.r.rs) ? wb_data_i : rf[iw.r.rs];
  assign rdata_b = (wb_en_i && wb_rd_i == rb) ? wb_data_i : rf[rb];

  //////////////////////////////
  // hazard against the entry now in execute
  assign uses_a = (opc == cpu_pkg::OP_RTYPE) || (opc == cpu_pkg::OP_ADDI) ||
                  (opc == cpu_pkg::OP_LD) || (opc == cpu_pkg::OP_ST);
  assign uses_b = (opc == cpu_pkg::OP_RTYPE) || (opc == cpu_pkg::OP_ST);

  assign dec_valid = if_valid_i && !halt_seen_q;  // nothing issues past a halt
  assign hazard    = dec_valid && ex_reg_write_i && !wb_en_i &&
                     ((uses_a && iw.r.rs == ex_rd_i) || (uses_b && rb == ex_rd_i));

  assign stall_decode_o = hazard;
  assign decode_hold_o  = dec_valid && (hazard || ex_busy_i);
  assign stop_fetch_o   = halt_seen_q || (dec_valid && opc == cpu_pkg::OP_HALT);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      halt_seen_q <= 1'b0;
    end else if (dec_valid && opc == cpu_pkg::OP_HALT && !decode_hold_o) begin
      halt_seen_q <= 1'b1;  // halt has moved on to execute
    end
  end

  always_comb begin
    dec            = cpu_pkg::ID_EX_BUBBLE;
    dec.valid      = 1'b1;
    dec.instr      = if_instr_i;
    dec.alu_fn     = cpu_pkg::FN_ADD;  // address and addi sums
    dec.rd         = iw.r.rd;
    dec.op_a       = rdata_a;
    dec.op_b       = rdata_b;
    dec.store_data = rdata_b;
    dec.imm        = {{(cpu_pkg::DATA_W-5){iw.i.imm[4]}}, iw.i.imm};
    case (opc)
      cpu_pkg::OP_RTYPE: begin
        dec.alu_fn    = iw.r.funct;
        dec.reg_write = 1'b1;
      end
      cpu_pkg::OP_ADDI: begin
        dec.alu_src   = 1'b1;
        dec.reg_write = 1'b1;
      end
      cpu_pkg::OP_LD: begin
        dec.alu_src   = 1'b1;
        dec.reg_write = 1'b1;
        dec.mem_read  = 1'b1;
      end
      cpu_pkg::OP_ST: begin
        dec.alu_src   = 1'b1;
        dec.mem_write = 1'b1;
      end
      cpu_pkg::OP_HALT: dec.halt = 1'b1;
      default: ;  // nop and unused opcodes pass through doing nothing
    endcase
    id_next_o = dec_valid ? dec : cpu_pkg::ID_EX_BUBBLE;
  end

  // every write lands, r0 included, one edge after execute offers it
  a_wb_lands : assert property (@(posedge clk) disable iff (reset_i)
    wb_en_i |=> rf[$past(wb_rd_i)] == $past(wb_data_i));

endmodule

//--- execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
  input  logic                       clk,
  input  logic                       reset_i,
  input  cpu_pkg::id_ex_t            id_ex_i,
  apb_if.master                      bus,
  output logic                       ex_busy_o,
  output logic                       wb_en_o,
  output logic [cpu_pkg::REG_W-1:0]  wb_rd_o,
  output logic [cpu_pkg::DATA_W-1:0] wb_data_o,
  output logic                       halted_o
);

  logic [cpu_pkg::DATA_W-1:0] alu_b;
  logic [cpu_pkg::DATA_W-1:0] alu_y;
  logic                       is_mem;
  logic                       done_mem;
  logic                       acc_q;  // apb access phase
  logic                       halted_q;

  //////////////////////////////
  // alu
  assign alu_b = id_ex_i.alu_src ? id_ex_i.imm : id_ex_i.op_b;

  always_comb begin
    case (id_ex_i.alu_fn)
      cpu_pkg::FN_SUB: alu_y = id_ex_i.op_a - alu_b;
      cpu_pkg::FN_AND: alu_y = id_ex_i.op_a & alu_b;
      cpu_pkg::FN_XOR: alu_y = id_ex_i.op_a ^ alu_b;
      default:         alu_y = id_ex_i.op_a + alu_b;
    endcase
  end

  //////////////////////////////
  // load and store
  assign is_mem   = id_ex_i.valid && (id_ex_i.mem_read || id_ex_i.mem_write);
  assign done_mem = acc_q && bus.pready;

  assign bus.psel    = is_mem;  // setup in the entry's first cycle
  assign bus.penable = acc_q;
  assign bus.paddr   = alu_y;
  assign bus.pwrite  = id_ex_i.mem_write;
  assign bus.pwdata  = id_ex_i.store_data;

  assign ex_busy_o = is_mem && !done_mem;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      acc_q    <= 1'b0;
      halted_q <= 1'b0;
    end else begin
      if (done_mem) begin
        acc_q <= 1'b0;
      end else if (is_mem) begin
        acc_q <= 1'b1;
      end
      if (id_ex_i.valid && id_ex_i.halt) halted_q <= 1'b1;  // sticky
    end
  end

  // alu results go back at once, loads when the data arrives
  assign wb_en_o   = id_ex_i.valid && id_ex_i.reg_write && (!id_ex_i.mem_read || done_mem);
  assign wb_rd_o   = id_ex_i.rd;
  assign wb_data_o = id_ex_i.mem_read ? bus.prdata : alu_y;
  assign halted_o  = halted_q;

  // the pipeline register must keep this entry until the access ends
  a_entry_held : assert property (@(posedge clk) disable iff (reset_i)
    ex_busy_o |=> $stable(id_ex_i.instr) && id_ex_i.valid);

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       run_i,
  input  logic                       decode_hold_i,
  input  logic                       stop_fetch_i,
  apb_if.master                      bus,
  output logic [cpu_pkg::DATA_W-1:0] if_instr_o,
  output logic                       if_valid_o
);

  logic [cpu_pkg::ADDR_W-1:0] pc_q;
  logic                       psel_q;
  logic                       penable_q;
  logic [cpu_pkg::DATA_W-1:0] if_instr_q;
  logic                       if_valid_q;
  logic                       take;   // decode consumes the word this cycle
  logic                       start;
  logic                       done;

  assign take  = if_valid_q && !decode_hold_i;
  // one fetch at a time, and only into an empty or draining register
  assign start = run_i && !stop_fetch_i && !psel_q && (!if_valid_q || take);
  assign done  = penable_q && bus.pready;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      pc_q       <= '0;
      psel_q     <= 1'b0;
      penable_q  <= 1'b0;
      if_valid_q <= 1'b0;
    end else begin
      if (start) begin
        psel_q <= 1'b1;  // setup
      end else if (done) begin
        psel_q    <= 1'b0;
        penable_q <= 1'b0;
      end else if (psel_q) begin
        penable_q <= 1'b1;  // access, wait for pready
      end
      if (done) begin
        if_valid_q <= 1'b1;
        pc_q       <= pc_q + 1'b1;
      end else if (take) begin
        if_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (done) if_instr_q <= bus.prdata;
  end

  assign bus.psel    = psel_q;
  assign bus.penable = penable_q;
  assign bus.paddr   = pc_q;
  assign bus.pwrite  = 1'b0;  // read only master
  assign bus.pwdata  = '0;

  assign if_instr_o = if_instr_q;
  assign if_valid_o = if_valid_q;

  // pc must not move while the arbiter may still be serving this address
  a_paddr_stable : assert property (@(posedge clk) disable iff (reset_i)
    bus.psel && bus.penable |-> $stable(bus.paddr));

endmodule

//--- mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic  clk,
  input  logic  reset_i,
  apb_if.slave  host_bus,
  apb_if.slave  data_bus,
  apb_if.slave  fetch_bus,
  apb_if.master mem_bus
);

  // one hot, bit 0 host, bit 1 data, bit 2 fetch
  logic [2:0] pick;
  logic [2:0] sel;
  logic [2:0] gnt_q;
  logic       busy_q;  // memory is in its access cycle for gnt_q

  assign pick = host_bus.psel ? 3'b001 :
                data_bus.psel ? 3'b010 :
                fetch_bus.psel ? 3'b100 : 3'b000;
  assign sel  = busy_q ? gnt_q : pick;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      gnt_q  <= '0;
    end else if (!busy_q && |pick) begin
      busy_q <= 1'b1;
      gnt_q  <= pick;
    end else if (busy_q && mem_bus.pready) begin
      busy_q <= 1'b0;  // transfer done, free for the next choice
    end
  end

  //////////////////////////////
  // request path
  always_comb begin
    mem_bus.paddr  = fetch_bus.paddr;
    mem_bus.pwrite = fetch_bus.pwrite;
    mem_bus.pwdata = fetch_bus.pwdata;
    if (sel[0]) begin
      mem_bus.paddr  = host_bus.paddr;
      mem_bus.pwrite = host_bus.pwrite;
      mem_bus.pwdata = host_bus.pwdata;
    end else if (sel[1]) begin
      mem_bus.paddr  = data_bus.paddr;
      mem_bus.pwrite = data_bus.pwrite;
      mem_bus.pwdata = data_bus.pwdata;
    end
  end

  assign mem_bus.psel    = busy_q || |pick;
  assign mem_bus.penable = busy_q;

  // response goes to the granted master alone
  assign host_bus.pready  = busy_q && gnt_q[0] && mem_bus.pready;
  assign data_bus.pready  = busy_q && gnt_q[1] && mem_bus.pready;
  assign fetch_bus.pready = busy_q && gnt_q[2] && mem_bus.pready;
  assign host_bus.prdata  = gnt_q[0] ? mem_bus.prdata : '0;
  assign data_bus.prdata  = gnt_q[1] ? mem_bus.prdata : '0;
  assign fetch_bus.prdata = gnt_q[2] ? mem_bus.prdata : '0;

  a_grant_held : assert property (@(posedge clk) disable iff (reset_i)
    mem_bus.psel && !(mem_bus.penable && mem_bus.pready) |=> $stable(sel));

endmodule

//--- pipe_id_ex.sv
`timescale 1ns/1ps

module pipe_id_ex (
  input  logic            clk,
  input  logic            reset_i,
  input  cpu_pkg::id_ex_t id_next_i,
  input  logic            stall_decode_i,
  input  logic            ex_busy_i,
  output cpu_pkg::id_ex_t id_ex_o
);

  cpu_pkg::id_ex_t id_ex_q;
  cpu_pkg::id_ex_t stall_entry;  // incoming entry turned into a nop
  cpu_pkg::id_ex_t id_ex_d;

  //////////////////////////////
  // bubble on a decode stall
  always_comb begin
    stall_entry           = id_next_i;
    stall_entry.valid     = 1'b0;
    stall_entry.instr     = cpu_pkg::NOP_WORD;
    stall_entry.reg_write = 1'b0;
    stall_entry.mem_read  = 1'b0;
    stall_entry.mem_write = 1'b0;
    stall_entry.halt      = 1'b0;
  end

  //////////////////////////////
  // hold beats bubble, bubble beats load
  always_comb begin
    if (ex_busy_i) begin
      id_ex_d = id_ex_q;  // execute still on its memory access
    end else if (stall_decode_i) begin
      id_ex_d = stall_entry;
    end else begin
      id_ex_d = id_next_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      id_ex_q <= cpu_pkg::ID_EX_BUBBLE;
    end else begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_ex_o = id_ex_q;

  // decode must hand over clean bubbles too, not only this register
  a_bubble_inert : assert property (@(posedge clk) disable iff (reset_i)
    !id_ex_q.valid |-> !(id_ex_q.reg_write || id_ex_q.mem_read ||
                         id_ex_q.mem_write || id_ex_q.halt));

endmodule

//--- tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

  localparam logic [31:0] SEED       = 32'h358e_e090;
  localparam int          CYC_PER_OP = 200;  // cycles allowed per program word
  localparam int          SETTLE     = 10;   // idle cycles after halt

  logic                       clk;
  logic                       reset_i;
  logic                       run_i;
  logic [cpu_pkg::ADDR_W-1:0] host_paddr_i;
  logic                       host_psel_i;
  logic                       host_penable_i;
  logic                       host_pwrite_i;
  logic [cpu_pkg::DATA_W-1:0] host_pwdata_i;
  logic [cpu_pkg::DATA_W-1:0] host_prdata_o;
  logic                       host_pready_o;
  logic                       halted_o;

  // reference model state
  logic [cpu_pkg::DATA_W-1:0] model_mem  [cpu_pkg::MEM_DEPTH];
  logic [cpu_pkg::DATA_W-1:0] model_regs [cpu_pkg::NUM_REGS];

  logic [cpu_pkg::DATA_W-1:0] prog_alu  [$];
  logic [cpu_pkg::DATA_W-1:0] prog_dep  [$];
  logic [cpu_pkg::DATA_W-1:0] prog_halt [$];

  logic                       check_en;
  logic [cpu_pkg::DATA_W-1:0] exp_data;
  logic                       fresh;  // between reset and the first run
  string                      test_name;
  int                         errors;
  int                         err_mark;
  int                         pass_count;
  int                         fail_count;
  int                         budget;

  cpu_top dut_i (
    .clk(clk), .reset_i(reset_i), .run_i(run_i),
    .host_paddr_i(host_paddr_i), .host_psel_i(host_psel_i),
    .host_penable_i(host_penable_i), .host_pwrite_i(host_pwrite_i),
    .host_pwdata_i(host_pwdata_i), .host_prdata_o(host_prdata_o),
    .host_pready_o(host_pready_o), .halted_o(halted_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // checks
  a_readback : assert property (@(posedge clk) disable iff (reset_i)
    check_en && host_pready_o |-> host_prdata_o == exp_data)
    else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", test_name,
               $sampled(exp_data), $sampled(host_prdata_o));
    end

  a_halted_reset : assert property (@(posedge clk) disable iff (reset_i)
    fresh |-> !halted_o)
    else begin
      errors++;
      $display("[ERROR] %s: expected halted_o 0, actual 1", test_name);
    end

  a_halt_sticky : assert property (@(posedge clk) disable iff (reset_i)
    halted_o |=> halted_o)
    else begin
      errors++;
      $display("[ERROR] %s: expected halted_o 1, actual 0", test_name);
    end

  // pready only answers a host request
  a_pready_idle : assert property (@(posedge clk) disable iff (reset_i)
    !host_psel_i |-> !host_pready_o)
    else begin
      errors++;
      $display("[ERROR] %s: expected host_pready_o 0, actual 1", test_name);
    end

  //////////////////////////////
  // instruction encoding
  function automatic logic [15:0] rtype(input logic [1:0] fn, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [2:0] rt);
    return {cpu_pkg::OP_RTYPE, rd, rs, rt, fn};
  endfunction

  function automatic logic [15:0] itype(input logic [4:0] op, input logic [2:0] rd,
                                        input logic [2:0] rs, input logic [4:0] imm);
    return {op, rd, rs, imm};
  endfunction

  // r7 = k * 16, starting from a cleared r7
  function automatic logic [15:0] base_word(input int i, input logic [4:0] k);
    if (i == 0) return rtype(cpu_pkg::FN_XOR, 3'd7, 3'd7, 3'd7);
    if (i == 1) return itype(cpu_pkg::OP_ADDI, 3'd7, 3'd7, k);
    return rtype(cpu_pkg::FN_ADD, 3'd7, 3'd7, 3'd7);  // doubling
  endfunction

  task automatic build_programs();
    logic [4:0] imm_a;
    logic [4:0] imm_b;
    int         i;
    imm_a = 5'($urandom);
    imm_b = 5'($urandom);
    for (i = 0; i < 6; i++) begin
      prog_alu.push_back(base_word(i, 5'd8));    // 0x80
      prog_dep.push_back(base_word(i, 5'd9));    // 0x90
      prog_halt.push_back(base_word(i, 5'd10));  // 0xa0
    end
    // every alu op on two loaded operands
    prog_alu.push_back(itype(cpu_pkg::OP_LD, 3'd1, 3'd7, 5'd0));
    prog_alu.push_back(itype(cpu_pkg::OP_LD, 3'd2, 3'd7, 5'd1));
    prog_alu.push_back(itype(cpu_pkg::OP_ADDI, 3'd3, 3'd1, imm_a));
    prog_alu.push_back(rtype(cpu_pkg::FN_ADD, 3'd4, 3'd1, 3'd2));
    prog_alu.push_back(rtype(cpu_pkg::FN_SUB, 3'd5, 3'd1, 3'd2));
    prog_alu.push_back(rtype(cpu_pkg::FN_AND, 3'd6, 3'd1, 3'd2));
    prog_alu.push_back(rtype(cpu_pkg::FN_XOR, 3'd0, 3'd1, 3'd2));
    for (i = 0; i < 5; i++) begin
      prog_alu.push_back(itype(cpu_pkg::OP_ST, 3'((i + 3) % 8), 3'd7, 5'(i + 2)));
    end
    prog_alu.push_back(cpu_pkg::OP_HALT << 11);
    // each word reads the result of the one before
    prog_dep.push_back(itype(cpu_pkg::OP_LD, 3'd1, 3'd7, 5'd0));
    prog_dep.push_back(itype(cpu_pkg::OP_ADDI, 3'd1, 3'd1, imm_b));  // load use
    prog_dep.push_back(rtype(cpu_pkg::FN_ADD, 3'd2, 3'd1, 3'd1));
    prog_dep.push_back(rtype(cpu_pkg::FN_SUB, 3'd3, 3'd2, 3'd1));
    prog_dep.push_back(rtype(cpu_pkg::FN_XOR, 3'd4, 3'd3, 3'd2));
    prog_dep.push_back(itype(cpu_pkg::OP_LD, 3'd5, 3'd7, 5'd1));
    prog_dep.push_back(itype(cpu_pkg::OP_ST, 3'd5, 3'd7, 5'd2));   // store of loaded reg
    prog_dep.push_back(rtype(cpu_pkg::FN_AND, 3'd6, 3'd4, 3'd5));
    prog_dep.push_back(itype(cpu_pkg::OP_LD, 3'd3, 3'd7, 5'd2));
    prog_dep.push_back(itype(cpu_pkg::OP_ST, 3'd6, 3'd7, 5'd3));
    prog_dep.push_back(itype(cpu_pkg::OP_ST, 3'd3, 3'd7, 5'd4));
    prog_dep.push_back(itype(cpu_pkg::OP_ST, 3'd4, 3'd7, 5'd5));
    prog_dep.push_back(itype(cpu_pkg::OP_ST, 3'd1, 3'd7, 5'd6));
    prog_dep.push_back(cpu_pkg::OP_HALT << 11);
    // the store after halt must never reach memory
    prog_halt.push_back(rtype(cpu_pkg::FN_XOR, 3'd1, 3'd1, 3'd1));
    prog_halt.push_back(itype(cpu_pkg::OP_ADDI, 3'd1, 3'd1, 5'd5));
    prog_halt.push_back(itype(cpu_pkg::OP_ST, 3'd1, 3'd7, 5'd1));
    prog_halt.push_back(cpu_pkg::OP_HALT << 11);
    prog_halt.push_back(itype(cpu_pkg::OP_ST, 3'd1, 3'd7, 5'd0));
  endtask

  //////////////////////////////
  // reference model, runs from word 0 until halt
  task automatic model_exec();
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] ea;
    logic [4:0]  opc;
    int          pc;
    pc = 0;
    while (pc < cpu_pkg::MEM_DEPTH) begin
      w   = model_mem[8'(pc)];
      pc  = pc + 1;
      opc = w[15:11];
      a   = model_regs[w[7:5]];
      b   = model_regs[w[4:2]];
      ea  = a + {{11{w[4]}}, w[4:0]};  // sign extended immediate
      if (opc == cpu_pkg::OP_HALT) break;
      case (opc)
        cpu_pkg::OP_ADDI: model_regs[w[10:8]] = ea;
        cpu_pkg::OP_LD:   model_regs[w[10:8]] = model_mem[ea[7:0]];
        cpu_pkg::OP_ST:   model_mem[ea[7:0]] = model_regs[w[10:8]];
        cpu_pkg::OP_RTYPE: begin
          case (w[1:0])
            cpu_pkg::FN_ADD: model_regs[w[10:8]] = a + b;
            cpu_pkg::FN_SUB: model_regs[w[10:8]] = a - b;
            cpu_pkg::FN_AND: model_regs[w[10:8]] = a & b;
            default:         model_regs[w[10:8]] = a ^ b;
          endcase
        end
        default: ;  // nop
      endcase
    end
  endtask

  //////////////////////////////
  // host port
  task automatic wait_pready();
    do @(posedge clk); while (!host_pready_o);
  endtask

  task automatic host_write(input logic [15:0] addr, input logic [15:0] data);
    @(posedge clk);
    host_paddr_i   <= addr;
    host_pwrite_i  <= 1'b1;
    host_pwdata_i  <= data;
    host_psel_i    <= 1'b1;  // setup
    host_penable_i <= 1'b0;
    @(posedge clk);
    host_penable_i <= 1'b1;
    wait_pready();
    host_psel_i    <= 1'b0;
    host_penable_i <= 1'b0;
    model_mem[addr[7:0]] = data;
  endtask

  task automatic read_check(input logic [15:0] addr);
    @(posedge clk);
    host_paddr_i   <= addr;
    host_pwrite_i  <= 1'b0;
    host_psel_i    <= 1'b1;
    host_penable_i <= 1'b0;
    exp_data       <= model_mem[addr[7:0]];
    check_en       <= 1'b1;
    @(posedge clk);
    host_penable_i <= 1'b1;
    wait_pready();
    host_psel_i    <= 1'b0;
    host_penable_i <= 1'b0;
    check_en       <= 1'b0;
  endtask

  //////////////////////////////
  // test flow
  task automatic reset_cpu();
    @(posedge clk);
    reset_i <= 1'b1;
    run_i   <= 1'b0;
    fresh   <= 1'b1;
    repeat (4) @(posedge clk);
    reset_i <= 1'b0;
  endtask

  task automatic run_prog(input int limit);
    int cycles;
    cycles = 0;
    @(posedge clk);
    run_i <= 1'b1;
    fresh <= 1'b0;
    while (!halted_o && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    run_i <= 1'b0;
    if (!halted_o) begin
      errors++;
      $display("%s: halted_o did not rise within %0d cycles", test_name, limit);
    end
    repeat (SETTLE) @(posedge clk);
  endtask

  task automatic program_test(input logic [15:0] prog [$], input int lo, input int n);
    int i;
    for (i = 0; i < prog.size(); i++) host_write(16'(i), prog[i]);
    model_exec();
    run_prog(CYC_PER_OP * prog.size());
    for (i = 0; i < n; i++) read_check(16'(lo + i));
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = errors;
  endtask

  task automatic finish_test();
    if (errors == err_mark) begin
      pass_count++;
      $display("test %s passed", test_name);
    end else begin
      fail_count++;
      $display("test %s failed with %0d errors", test_name, errors - err_mark);
    end
  endtask

  initial begin
    int i;
    void'($urandom(SEED));
    reset_i        <= 1'b1;
    run_i          <= 1'b0;
    host_paddr_i   <= '0;
    host_psel_i    <= 1'b0;
    host_penable_i <= 1'b0;
    host_pwrite_i  <= 1'b0;
    host_pwdata_i  <= '0;
    check_en       <= 1'b0;
    exp_data       <= '0;
    fresh          <= 1'b1;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    for (i = 0; i < cpu_pkg::NUM_REGS; i++) model_regs[i] = '0;
    build_programs();
    budget = CYC_PER_OP * (prog_alu.size() + prog_dep.size() + prog_halt.size());

    start_test("reset_state");
    reset_cpu();
    repeat (8) @(posedge clk);
    finish_test();

    start_test("host_access");
    for (i = 0; i < 16; i++) host_write(16'('hc0 + i), 16'($urandom));
    for (i = 0; i < 16; i++) read_check(16'('hc0 + i));
    finish_test();

    start_test("alu_program");
    reset_cpu();
    host_write(16'h0080, 16'($urandom));
    host_write(16'h0081, 16'($urandom));
    program_test(prog_alu, 'h82, 5);
    finish_test();

    start_test("dependent_sequence");
    reset_cpu();
    host_write(16'h0090, 16'($urandom));
    host_write(16'h0091, 16'($urandom));
    program_test(prog_dep, 'h92, 5);
    finish_test();

    start_test("halt");
    reset_cpu();
    host_write(16'h00a0, 16'($urandom));  // marker the late store would overwrite
    host_write(16'h00a1, 16'($urandom));
    program_test(prog_halt, 'ha0, 2);
    finish_test();

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog, sized once the programs exist
  initial begin
    wait (budget != 0);
    repeat (budget) @(posedge clk);
    $display("timeout: run did not end within %0d cycles", budget);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- unified_mem.sv
`timescale 1ns/1ps

module unified_mem (
  input  logic clk,
  input  logic reset_i,
  apb_if.slave bus
);

  localparam int AW = $clog2(cpu_pkg::MEM_DEPTH);

  logic [cpu_pkg::DATA_W-1:0] mem [cpu_pkg::MEM_DEPTH];  // program and data
  logic [AW-1:0]              word_addr;
  logic                       access;

  assign word_addr = bus.paddr[AW-1:0];
  assign access    = bus.psel && bus.penable;

  always_ff @(posedge clk) begin
    if (access && bus.pwrite) mem[word_addr] <= bus.pwdata;
  end

  assign bus.pready = access;  // never waits
  assign bus.prdata = mem[word_addr];

  // upper address bits are dropped, so programs must stay inside the array
  a_addr_range : assert property (@(posedge clk) disable iff (reset_i)
    bus.psel |-> bus.paddr < cpu_pkg::MEM_DEPTH);

endmodule
